// ==== verilog/core_settings.svh ====
`ifndef CORE_SETTINGS_SVH
`define CORE_SETTINGS_SVH

`define XLEN 32
`define REG_ADDR_W 4
`define REG_COUNT 16
`define CSR_ADDR_W 12

`define MCAUSE_ECALL 11
`define MSTATUS_RESET 'h1800

`endif

// ==== verilog/inst_pkg.sv ====
package inst_pkg;

	// one value per major instruction group
	typedef enum logic [3:0] {
		cls_lui,
		cls_auipc,
		cls_jal,
		cls_jalr,
		cls_branch,
		cls_load,
		cls_store,
		cls_op_imm,
		cls_op,
		cls_csr,
		cls_system
	} inst_class_t;

	typedef enum logic [3:0] {
		alu_add, alu_sub, alu_and, alu_xor, alu_or,
		alu_srl, alu_sra, alu_sll, alu_slt, alu_sltu
	} alu_op_t;

endpackage

// ==== verilog/csr_pkg.sv ====
`include "core_settings.svh"

package csr_pkg;

	typedef enum logic [`CSR_ADDR_W-1:0] {
		csr_mstatus = 'h300,
		csr_mtvec   = 'h305,
		csr_mepc    = 'h341,
		csr_mcause  = 'h342
	} csr_addr_t;

	typedef enum logic [1:0] {
		csr_op_none, csr_op_write, csr_op_set
	} csr_op_t;

endpackage

// ==== verilog/decoder.sv ====
`include "core_settings.svh"

module decoder import inst_pkg::*; (
	input  logic [31:0]             inst,
	output inst_class_t             inst_class,
	output logic [`REG_ADDR_W-1:0]  rd,
	output logic [`REG_ADDR_W-1:0]  rs1,
	output logic [`REG_ADDR_W-1:0]  rs2,
	output logic [`XLEN-1:0]        imm,
	output logic [2:0]              funct3,
	output logic                    funct7_5,
	output logic                    reg_wen,
	output logic                    inst_ecall,
	output logic                    inst_mret
);

	typedef enum logic [6:0] {
		opc_lui    = 7'b0110111,
		opc_auipc  = 7'b0010111,
		opc_jal    = 7'b1101111,
		opc_jalr   = 7'b1100111,
		opc_branch = 7'b1100011,
		opc_load   = 7'b0000011,
		opc_store  = 7'b0100011,
		opc_op_imm = 7'b0010011,
		opc_op     = 7'b0110011,
		opc_system = 7'b1110011
	} opcode_t;

	inst_class_t cls;
	logic        legal;
	logic [11:0] funct12;

	assign funct12 = inst[31:20];

	always_comb begin
		cls = cls_op_imm;
		legal = 1'b1;
		case (inst[6:0])
			opc_lui:    cls = cls_lui;
			opc_auipc:  cls = cls_auipc;
			opc_jal:    cls = cls_jal;
			opc_jalr:   cls = cls_jalr;
			opc_branch: cls = cls_branch;
			opc_load: begin
				cls = cls_load;
				legal = (inst[14:12] == 3'b010); // lw only
			end
			opc_store: begin
				cls = cls_store;
				legal = (inst[14:12] == 3'b010); // sw only
			end
			opc_op_imm: cls = cls_op_imm;
			opc_op:     cls = cls_op;
			opc_system: begin
				if (inst[14:12] == 3'b001 || inst[14:12] == 3'b010) begin
					cls = cls_csr; // csrrw / csrrs
				end else begin
					cls = cls_system;
					legal = (inst[14:12] == 3'b000) && (funct12 == 12'h000 || funct12 == 12'h302);
				end
			end
			default: legal = 1'b0;
		endcase
	end

	// anything unsupported becomes addi x0 with no write
	assign inst_class = legal ? cls : cls_op_imm;
	assign rd = legal ? inst[10:7] : '0;
	assign rs1 = inst[18:15];
	assign rs2 = inst[23:20];
	assign funct3 = legal ? inst[14:12] : 3'b000;
	assign funct7_5 = legal & inst[30];
	assign reg_wen = legal && !(cls inside {cls_branch, cls_store, cls_system});
	assign inst_ecall = legal && cls == cls_system && funct12 == 12'h000;
	assign inst_mret = legal && cls == cls_system && funct12 == 12'h302;

	always_comb begin
		case (cls)
			cls_lui, cls_auipc: imm = {inst[31:12], 12'b0};
			cls_jal:    imm = {{12{inst[31]}}, inst[19:12], inst[20], inst[30:21], 1'b0};
			cls_branch: imm = {{20{inst[31]}}, inst[7], inst[30:25], inst[11:8], 1'b0};
			cls_store:  imm = {{20{inst[31]}}, inst[31:25], inst[11:7]};
			default:    imm = {{20{inst[31]}}, inst[31:20]}; // I type, csr address too
		endcase
	end

endmodule

// ==== verilog/register_file.sv ====
`include "core_settings.svh"

module register_file (
	input  logic                    clock,
	input  logic                    rst,
	input  logic [`REG_ADDR_W-1:0]  rs1,
	input  logic [`REG_ADDR_W-1:0]  rs2,
	input  logic                    wen,
	input  logic [`REG_ADDR_W-1:0]  waddr,
	input  logic [`XLEN-1:0]        wdata,
	output logic [`XLEN-1:0]        rdata1,
	output logic [`XLEN-1:0]        rdata2
);

	logic [`XLEN-1:0] regs [`REG_COUNT];

	always_ff @(posedge clock) begin
		if (rst) begin
			for (int i = 0; i < `REG_COUNT; i++) begin
				regs[i] <= '0;
			end
		end else if (wen && waddr != '0) begin
			regs[waddr] <= wdata;
		end
	end

	assign rdata1 = (rs1 == '0) ? '0 : regs[rs1]; // x0 reads zero
	assign rdata2 = (rs2 == '0) ? '0 : regs[rs2];

endmodule

// ==== verilog/alu.sv ====
`include "core_settings.svh"

module alu import inst_pkg::*; (
	input  inst_class_t       inst_class,
	input  logic [2:0]        funct3,
	input  logic              funct7_5,
	input  logic [`XLEN-1:0]  loperand,
	input  logic [`XLEN-1:0]  roperand,
	output logic [`XLEN-1:0]  result
);

	alu_op_t          op;
	logic [`XLEN-1:0] diff;
	logic             borrow;
	logic             less;
	logic [4:0]       shamt;

	always_comb begin
		op = alu_add; // address and target arithmetic
		if (inst_class == cls_op_imm || inst_class == cls_op) begin
			case (funct3)
				3'b000: op = (inst_class == cls_op && funct7_5) ? alu_sub : alu_add;
				3'b001: op = alu_sll;
				3'b010: op = alu_slt;
				3'b011: op = alu_sltu;
				3'b100: op = alu_xor;
				3'b101: op = funct7_5 ? alu_sra : alu_srl;
				3'b110: op = alu_or;
				default: op = alu_and;
			endcase
		end
	end

	assign {borrow, diff} = {1'b0, loperand} - {1'b0, roperand};
	assign less = (loperand[`XLEN-1] & ~roperand[`XLEN-1]) |
		(~(loperand[`XLEN-1] ^ roperand[`XLEN-1]) & diff[`XLEN-1]);
	assign shamt = roperand[4:0];

	always_comb begin
		case (op)
			alu_sub:  result = diff;
			alu_and:  result = loperand & roperand;
			alu_xor:  result = loperand ^ roperand;
			alu_or:   result = loperand | roperand;
			alu_srl:  result = loperand >> shamt;
			alu_sra:  result = $signed(loperand) >>> shamt;
			alu_sll:  result = loperand << shamt;
			alu_slt:  result = {{(`XLEN-1){1'b0}}, less};
			alu_sltu: result = {{(`XLEN-1){1'b0}}, borrow};
			default:  result = loperand + roperand;
		endcase
	end

endmodule

// ==== verilog/execute_unit.sv ====
`include "core_settings.svh"

module execute_unit import inst_pkg::*, csr_pkg::*; (
	input  logic                    clock,
	input  logic                    rst,
	input  inst_class_t             inst_class_in,
	input  logic [`REG_ADDR_W-1:0]  rd_in,
	input  logic [`XLEN-1:0]        src1_in,
	input  logic [`XLEN-1:0]        src2_in,
	input  logic [`XLEN-1:0]        imm_in,
	input  logic [2:0]              funct3_in,
	input  logic                    funct7_5_in,
	input  logic [`XLEN-1:0]        pc_in,
	input  logic                    reg_wen_in,
	input  logic                    inst_ecall_in,
	input  logic                    inst_mret_in,
	input  logic                    csr_jump_en,
	input  logic [`XLEN-1:0]        csr_jump,
	input  logic [`XLEN-1:0]        csr_val,
	input  logic                    exu_valid,
	input  logic                    lsu_ready,
	output logic [`XLEN-1:0]        pc,
	output logic [`REG_ADDR_W-1:0]  rd,
	output inst_class_t             inst_class,
	output logic                    reg_wen,
	output logic                    inst_ecall,
	output logic                    inst_mret,
	output logic                    exu_complete,
	output logic [`XLEN-1:0]        val,
	output logic [`XLEN-1:0]        lsu_data,
	output logic [`XLEN-1:0]        jump_addr,
	output logic                    jump_wrong,
	output logic [`XLEN-1:0]        csr_wdata,
	output logic [`CSR_ADDR_W-1:0]  csr_addr,
	output logic                    csr_enable,
	output logic                    lsu_ren,
	output logic                    lsu_wen,
	output logic                    exu_ready,
	output logic                    lsu_valid
);

	logic [`XLEN-1:0] src1;
	logic [`XLEN-1:0] src2;
	logic [`XLEN-1:0] imm;
	logic [2:0]       funct3;
	logic             funct7_5;
	logic             accept;
	logic [`XLEN-1:0] snpc;
	logic [`XLEN-1:0] loperand;
	logic [`XLEN-1:0] roperand;
	logic [`XLEN-1:0] alu_val;
	logic [`XLEN-1:0] target;
	logic [`XLEN:0]   cmp;
	logic             less;
	logic             branch_cond;
	logic             jump_en;
	logic             is_jump;
	logic [`XLEN-1:0] csr_old;
	csr_op_t          csr_op;

	assign accept = exu_valid & exu_ready;

	always_ff @(posedge clock) begin
		if (rst) begin
			exu_ready <= 1'b1;
			lsu_valid <= 1'b0;
			exu_complete <= 1'b0;
			inst_class <= cls_op_imm;
			reg_wen <= 1'b0;
			inst_ecall <= 1'b0;
			inst_mret <= 1'b0;
		end else begin
			exu_complete <= accept; // one cycle after accept
			if (accept) begin
				exu_ready <= 1'b0;
				lsu_valid <= 1'b1;
				inst_class <= inst_class_in;
				reg_wen <= reg_wen_in;
				inst_ecall <= inst_ecall_in;
				inst_mret <= inst_mret_in;
			end else if (lsu_valid && lsu_ready) begin
				exu_ready <= 1'b1; // write-back done
				lsu_valid <= 1'b0;
			end
		end
	end

	always_ff @(posedge clock) begin
		if (accept) begin
			rd <= rd_in;
			src1 <= src1_in;
			src2 <= src2_in;
			imm <= imm_in;
			funct3 <= funct3_in;
			funct7_5 <= funct7_5_in;
			pc <= pc_in;
		end
	end

	always_ff @(posedge clock) begin
		if (exu_complete) begin
			csr_old <= csr_val; // read value before the csr write
		end
	end

	assign loperand = (inst_class inside {cls_auipc, cls_jal, cls_branch}) ? pc :
		(inst_class == cls_lui) ? '0 : src1;
	assign roperand = (inst_class == cls_op) ? src2 : imm;

	alu i_alu (
		.inst_class (inst_class),
		.funct3     (funct3),
		.funct7_5   (funct7_5),
		.loperand   (loperand),
		.roperand   (roperand),
		.result     (alu_val)
	);

	// branch compare on the register operands
	assign cmp = {1'b0, src1} - {1'b0, src2};
	assign less = (src1[`XLEN-1] & ~src2[`XLEN-1]) |
		(~(src1[`XLEN-1] ^ src2[`XLEN-1]) & cmp[`XLEN-1]);

	always_comb begin
		case (funct3)
			3'b000: branch_cond = (cmp[`XLEN-1:0] == '0);
			3'b001: branch_cond = (cmp[`XLEN-1:0] != '0);
			3'b100: branch_cond = less;
			3'b101: branch_cond = ~less;
			3'b110: branch_cond = cmp[`XLEN]; // borrow
			3'b111: branch_cond = ~cmp[`XLEN];
			default: branch_cond = 1'b0;
		endcase
	end

	assign snpc = pc + `XLEN'(4);
	assign is_jump = (inst_class == cls_jal) || (inst_class == cls_jalr);
	assign jump_en = is_jump || (inst_class == cls_branch && branch_cond);
	assign target = (inst_class == cls_jalr) ? {alu_val[`XLEN-1:1], 1'b0} : alu_val;
	assign jump_addr = csr_jump_en ? csr_jump : jump_en ? target : snpc;
	assign jump_wrong = (jump_addr != snpc) & exu_complete;

	always_comb begin
		csr_op = csr_op_none;
		if (inst_class == cls_csr) begin
			case (funct3)
				3'b001: csr_op = csr_op_write;
				3'b010: csr_op = csr_op_set;
				default: csr_op = csr_op_none;
			endcase
		end
	end

	assign csr_enable = (csr_op != csr_op_none);
	assign csr_addr = imm[`CSR_ADDR_W-1:0];
	assign csr_wdata = (csr_op == csr_op_set) ? (src1 | csr_val) :
		(csr_op == csr_op_write) ? src1 : '0;

	assign val = is_jump ? snpc :
		csr_enable ? (exu_complete ? csr_val : csr_old) : alu_val; // old csr value to rd
	assign lsu_ren = (inst_class == cls_load);
	assign lsu_wen = (inst_class == cls_store);
	assign lsu_data = src2;

endmodule

// ==== verilog/csr_file.sv ====
`include "core_settings.svh"

module csr_file import csr_pkg::*; (
	input  logic                    clock,
	input  logic                    rst,
	input  logic [`CSR_ADDR_W-1:0]  csr_addr,
	input  logic [`XLEN-1:0]        csr_wdata,
	input  logic                    csr_enable,
	input  logic                    exu_complete,
	input  logic                    inst_ecall,
	input  logic                    inst_mret,
	input  logic [`XLEN-1:0]        pc,
	output logic [`XLEN-1:0]        csr_val,
	output logic                    csr_jump_en,
	output logic [`XLEN-1:0]        csr_jump
);

	logic [`XLEN-1:0] mstatus;
	logic [`XLEN-1:0] mtvec;
	logic [`XLEN-1:0] mepc;
	logic [`XLEN-1:0] mcause;

	always_comb begin
		case (csr_addr)
			csr_mstatus: csr_val = mstatus;
			csr_mtvec:   csr_val = mtvec;
			csr_mepc:    csr_val = mepc;
			csr_mcause:  csr_val = mcause;
			default:     csr_val = '0; // unimplemented
		endcase
	end

	always_ff @(posedge clock) begin
		if (rst) begin
			mstatus <= `XLEN'(`MSTATUS_RESET); // MPP = machine
			mtvec <= '0;
			mepc <= '0;
			mcause <= '0;
		end else if (exu_complete) begin
			if (csr_enable) begin
				case (csr_addr)
					csr_mstatus: mstatus <= csr_wdata;
					csr_mtvec:   mtvec <= csr_wdata;
					csr_mepc:    mepc <= csr_wdata;
					csr_mcause:  mcause <= csr_wdata;
					default: ;
				endcase
			end
			if (inst_ecall) begin
				mepc <= pc;
				mcause <= `XLEN'(`MCAUSE_ECALL);
			end
		end
	end

	assign csr_jump_en = inst_ecall | inst_mret;
	assign csr_jump = inst_ecall ? mtvec : mepc; // trap entry or return
endmodule

// ==== verilog/exec_core.sv ====
`include "core_settings.svh"

module exec_core import inst_pkg::*; (
	input  logic                    clock,
	input  logic                    rst,
	input  logic [31:0]             inst,
	input  logic [`XLEN-1:0]        pc,
	input  logic                    inst_valid,
	output logic                    inst_ready,
	output logic                    lsu_valid,
	input  logic                    lsu_ready,
	output logic                    lsu_ren,
	output logic                    lsu_wen,
	output logic [`XLEN-1:0]        lsu_addr,
	output logic [`XLEN-1:0]        lsu_data,
	input  logic [`XLEN-1:0]        lsu_rdata,
	output logic [`XLEN-1:0]        next_pc,
	output logic                    redirect,
	output logic                    wb_en,
	output logic [`REG_ADDR_W-1:0]  wb_rd,
	output logic [`XLEN-1:0]        wb_data
);

	inst_class_t             dec_class;
	inst_class_t             exu_class;
	logic [`REG_ADDR_W-1:0]  dec_rd;
	logic [`REG_ADDR_W-1:0]  rs1;
	logic [`REG_ADDR_W-1:0]  rs2;
	logic [`XLEN-1:0]        dec_imm;
	logic [2:0]              dec_funct3;
	logic                    dec_funct7_5;
	logic                    dec_reg_wen;
	logic                    dec_ecall;
	logic                    dec_mret;
	logic [`XLEN-1:0]        src1;
	logic [`XLEN-1:0]        src2;
	logic [`XLEN-1:0]        exu_pc;
	logic                    exu_reg_wen;
	logic                    exu_ecall;
	logic                    exu_mret;
	logic                    exu_complete;
	logic [`XLEN-1:0]        val;
	logic [`XLEN-1:0]        csr_wdata;
	logic [`CSR_ADDR_W-1:0]  csr_addr;
	logic                    csr_enable;
	logic [`XLEN-1:0]        csr_val;
	logic                    csr_jump_en;
	logic [`XLEN-1:0]        csr_jump;

	decoder i_decoder (
		.inst (inst), .inst_class (dec_class), .rd (dec_rd), .rs1 (rs1), .rs2 (rs2),
		.imm (dec_imm), .funct3 (dec_funct3), .funct7_5 (dec_funct7_5),
		.reg_wen (dec_reg_wen), .inst_ecall (dec_ecall), .inst_mret (dec_mret)
	);

	register_file i_register_file (
		.clock (clock), .rst (rst), .rs1 (rs1), .rs2 (rs2),
		.wen (wb_en), .waddr (wb_rd), .wdata (wb_data),
		.rdata1 (src1), .rdata2 (src2)
	);

	execute_unit i_execute_unit (
		.clock (clock), .rst (rst),
		.inst_class_in (dec_class), .rd_in (dec_rd), .src1_in (src1), .src2_in (src2),
		.imm_in (dec_imm), .funct3_in (dec_funct3), .funct7_5_in (dec_funct7_5),
		.pc_in (pc), .reg_wen_in (dec_reg_wen),
		.inst_ecall_in (dec_ecall), .inst_mret_in (dec_mret),
		.csr_jump_en (csr_jump_en), .csr_jump (csr_jump), .csr_val (csr_val),
		.exu_valid (inst_valid), .lsu_ready (lsu_ready),
		.pc (exu_pc), .rd (wb_rd), .inst_class (exu_class), .reg_wen (exu_reg_wen),
		.inst_ecall (exu_ecall), .inst_mret (exu_mret), .exu_complete (exu_complete),
		.val (val), .lsu_data (lsu_data), .jump_addr (next_pc), .jump_wrong (redirect),
		.csr_wdata (csr_wdata), .csr_addr (csr_addr), .csr_enable (csr_enable),
		.lsu_ren (lsu_ren), .lsu_wen (lsu_wen),
		.exu_ready (inst_ready), .lsu_valid (lsu_valid)
	);

	csr_file i_csr_file (
		.clock (clock), .rst (rst), .csr_addr (csr_addr), .csr_wdata (csr_wdata),
		.csr_enable (csr_enable), .exu_complete (exu_complete),
		.inst_ecall (exu_ecall), .inst_mret (exu_mret), .pc (exu_pc),
		.csr_val (csr_val), .csr_jump_en (csr_jump_en), .csr_jump (csr_jump)
	);

	assign lsu_addr = val;
	assign wb_en = lsu_valid & lsu_ready & exu_reg_wen; // write-back at the memory handshake
	assign wb_data = (exu_class == cls_load) ? lsu_rdata : val;

endmodule

// ==== bench/exec_core_tb.sv ====
module exec_core_tb;
	timeunit 1ns;
	timeprecision 1ns;

	localparam logic [6:0] opc_op_imm = 7'b0010011;
	localparam logic [6:0] opc_op = 7'b0110011;
	localparam logic [6:0] opc_system = 7'b1110011;

	logic clock = 1'b0;
	logic rst, inst_valid, inst_ready, lsu_valid, lsu_ready, lsu_ren, lsu_wen;
	logic redirect, wb_en;
	logic [31:0] inst, pc, lsu_addr, lsu_data, lsu_rdata, next_pc, wb_data;
	logic [3:0] wb_rd;

	logic [31:0] regs [16]; // shadow register file
	logic [31:0] mem [64];
	logic [31:0] shadow_mem [64];
	logic [31:0] mstatus_m, mtvec_m, mepc_m, mcause_m;
	logic [31:0] pc_cur, exp_data, exp_next, exp_addr, exp_sdata;
	logic [3:0] exp_rd;
	logic exp_wen, exp_redirect, exp_ren, exp_store;

	exec_core i_exec_core (.*);

	always #50 clock = ~clock;

	task automatic stop_run(input string line);
		$display("%s", line);
		$display("SOME TESTS FAILED");
		$fatal(1);
	endtask

	// expectations change only at falling edges
	assert property (@(posedge clock) disable iff (rst)
			(lsu_valid && lsu_ready) |-> wb_en == exp_wen)
		else stop_run($sformatf("mismatch wb_en: got %h expected %h", wb_en, exp_wen));
	assert property (@(posedge clock) disable iff (rst) !(lsu_valid && lsu_ready) |-> !wb_en)
		else stop_run("wb_en was high outside a memory handshake");
	assert property (@(posedge clock) disable iff (rst) wb_en |-> wb_rd == exp_rd)
		else stop_run($sformatf("mismatch wb_rd: got %h expected %h", wb_rd, exp_rd));
	assert property (@(posedge clock) disable iff (rst) wb_en |-> wb_data == exp_data)
		else stop_run($sformatf("mismatch wb_data: got %h expected %h", wb_data, exp_data));
	assert property (@(posedge clock) disable iff (rst)
			(inst_valid && inst_ready) |=> next_pc == exp_next)
		else stop_run($sformatf("mismatch next_pc: got %h expected %h", next_pc, exp_next));
	assert property (@(posedge clock) disable iff (rst)
			(inst_valid && inst_ready) |=> redirect == exp_redirect)
		else stop_run($sformatf("mismatch redirect: got %h expected %h", redirect,
			exp_redirect));
	assert property (@(posedge clock) disable iff (rst) !(inst_valid && inst_ready) |=> !redirect)
		else stop_run("redirect was high outside the cycle after an accept");
	assert property (@(posedge clock) disable iff (rst) lsu_valid |-> lsu_ren == exp_ren)
		else stop_run($sformatf("mismatch lsu_ren: got %h expected %h", lsu_ren, exp_ren));
	assert property (@(posedge clock) disable iff (rst) lsu_valid |-> lsu_wen == exp_store)
		else stop_run($sformatf("mismatch lsu_wen: got %h expected %h", lsu_wen, exp_store));
	assert property (@(posedge clock) disable iff (rst)
			(lsu_valid && (exp_ren || exp_store)) |-> lsu_addr == exp_addr)
		else stop_run($sformatf("mismatch lsu_addr: got %h expected %h", lsu_addr, exp_addr));
	assert property (@(posedge clock) disable iff (rst)
			(lsu_valid && exp_store) |-> lsu_data == exp_sdata)
		else stop_run($sformatf("mismatch lsu_data: got %h expected %h", lsu_data, exp_sdata));
	assert property (@(posedge clock) disable iff (rst)
			(lsu_valid && !lsu_ready) |=> lsu_valid && $stable(lsu_addr))
		else stop_run("lsu_valid or lsu_addr changed while lsu_ready was low");
	assert property (@(posedge clock) disable iff (rst) lsu_valid |-> !inst_ready)
		else stop_run("inst_ready was high during a memory request");

	function automatic logic [31:0] enc_i(input logic [11:0] imm, input logic [3:0] rs1,
			input logic [2:0] f3, input logic [3:0] rd, input logic [6:0] opc);
		return {imm, 1'b0, rs1, f3, 1'b0, rd, opc};
	endfunction

	function automatic logic [31:0] enc_r(input logic alt, input logic [3:0] rs2,
			input logic [3:0] rs1, input logic [2:0] f3, input logic [3:0] rd);
		return {1'b0, alt, 5'b0, 1'b0, rs2, 1'b0, rs1, f3, 1'b0, rd, opc_op};
	endfunction

	function automatic logic [31:0] enc_s(input logic [11:0] imm, input logic [3:0] rs2,
			input logic [3:0] rs1);
		return {imm[11:5], 1'b0, rs2, 1'b0, rs1, 3'b010, imm[4:0], 7'b0100011};
	endfunction

	function automatic logic [31:0] enc_b(input logic [12:0] imm, input logic [3:0] rs2,
			input logic [3:0] rs1, input logic [2:0] f3);
		return {imm[12], imm[10:5], 1'b0, rs2, 1'b0, rs1, f3, imm[4:1], imm[11], 7'b1100011};
	endfunction

	function automatic logic [31:0] enc_j(input logic [20:0] imm, input logic [3:0] rd);
		return {imm[20], imm[10:1], imm[11], imm[19:12], 1'b0, rd, 7'b1101111};
	endfunction

	function automatic logic [31:0] alu_ref(input logic [2:0] f3, input logic alt,
			input logic [31:0] a, input logic [31:0] b);
		case (f3)
			3'd0: return alt ? a - b : a + b;
			3'd1: return a << b[4:0];
			3'd2: return {31'b0, $signed(a) < $signed(b)};
			3'd3: return {31'b0, a < b};
			3'd4: return a ^ b;
			3'd5: return alt ? 32'($signed(a) >>> b[4:0]) : a >> b[4:0];
			3'd6: return a | b;
			default: return a & b;
		endcase
	endfunction

	function automatic logic taken_ref(input logic [2:0] f3, input logic [31:0] a,
			input logic [31:0] b);
		case (f3)
			3'd0: return a == b;
			3'd1: return a != b;
			3'd4: return $signed(a) < $signed(b);
			3'd5: return $signed(a) >= $signed(b);
			3'd6: return a < b;
			default: return a >= b;
		endcase
	endfunction

	function automatic logic [31:0] csr_read(input logic [11:0] addr);
		case (addr)
			12'h300: return mstatus_m;
			12'h305: return mtvec_m;
			12'h341: return mepc_m;
			12'h342: return mcause_m;
			default: return 32'h0; // not implemented
		endcase
	endfunction

	// one instruction through accept, memory handshake and write-back
	task automatic issue(input logic [31:0] word, input logic wen, input logic [3:0] rd,
			input logic [31:0] data, input logic [31:0] target,
			input logic [31:0] addr, input logic [31:0] sdata);
		int t;
		int delay;
		logic store;
		logic [5:0] idx;
		logic [31:0] wdata;
		exp_wen = wen;
		exp_rd = rd;
		exp_data = data;
		exp_next = target;
		exp_redirect = (target != pc_cur + 32'd4);
		exp_addr = addr;
		exp_sdata = sdata;
		exp_ren = (word[6:0] == 7'b0000011);
		exp_store = (word[6:0] == 7'b0100011);
		t = 0;
		while (!inst_ready) begin
			if (t == 50) stop_run("timed out waiting for inst_ready");
			t++;
			@(negedge clock);
		end
		inst = word;
		pc = pc_cur;
		inst_valid = 1'b1;
		@(negedge clock);
		inst_valid = 1'b0;
		t = 0;
		while (!lsu_valid) begin
			if (t == 50) stop_run("timed out waiting for lsu_valid");
			t++;
			@(negedge clock);
		end
		delay = int'($urandom % 4); // back-pressure
		repeat (delay) @(negedge clock);
		idx = lsu_addr[7:2];
		store = lsu_wen;
		wdata = lsu_data;
		lsu_rdata = mem[idx];
		lsu_ready = 1'b1;
		@(negedge clock);
		lsu_ready = 1'b0;
		if (store) mem[idx] = wdata;
		if (wen && rd != 4'd0) regs[rd] = data;
		pc_cur = target;
	endtask

	task automatic csr_op(input logic [2:0] f3, input logic [3:0] rd, input logic [3:0] rs1,
			input logic [11:0] addr);
		logic [31:0] old;
		logic [31:0] src;
		old = csr_read(addr);
		src = regs[rs1];
		issue(enc_i(addr, rs1, f3, rd, opc_system), 1'b1, rd, old, pc_cur + 32'd4, 0, 0);
		case (addr)
			12'h300: mstatus_m = (f3 == 3'b001) ? src : old | src;
			12'h305: mtvec_m = (f3 == 3'b001) ? src : old | src;
			12'h341: mepc_m = (f3 == 3'b001) ? src : old | src;
			12'h342: mcause_m = (f3 == 3'b001) ? src : old | src;
			default: ;
		endcase
	endtask

	initial begin
		logic [31:0] v, hi, b, addr, ecall_pc;
		logic [11:0] imm;
		logic [12:0] boff;
		logic [20:0] joff;
		logic [3:0] rd, rs1, rs2;
		logic [2:0] f3;
		logic alt;
		int w;
		void'($urandom(32'ha611));
		rst = 1'b1;
		inst = 32'h0;
		pc = 32'h0;
		inst_valid = 1'b0;
		lsu_ready = 1'b0;
		lsu_rdata = 32'h0;
		pc_cur = 32'h100;
		mstatus_m = 32'h1800;
		mtvec_m = 32'h0;
		mepc_m = 32'h0;
		mcause_m = 32'h0;
		for (int i = 0; i < 16; i++) regs[i] = 32'h0;
		for (int i = 0; i < 64; i++) begin
			mem[i] = 32'(i) * 32'h9e3779b1 ^ 32'h5a5a0000;
			shadow_mem[i] = mem[i];
		end
		repeat (8) @(posedge clock);
		@(negedge clock);
		rst = 1'b0;
		@(negedge clock);
		assert (inst_ready && !lsu_valid && !wb_en && !redirect)
			else stop_run("outputs not in their reset state");

		for (int r = 1; r < 16; r++) begin // load every register with lui and addi
			v = $urandom;
			hi = {v[31:12] + 20'(v[11]), 12'h0};
			issue({hi[31:12], 1'b0, 4'(r), 7'b0110111}, 1'b1, 4'(r), hi, pc_cur + 32'd4, 0, 0);
			issue(enc_i(v[11:0], 4'(r), 3'd0, 4'(r), opc_op_imm), 1'b1, 4'(r), v,
				pc_cur + 32'd4, 0, 0);
		end
		issue(enc_i(12'h7, 4'd5, 3'd0, 4'd0, opc_op_imm), 1'b1, 4'd0, regs[5] + 32'd7,
			pc_cur + 32'd4, 0, 0);
		issue(enc_r(1'b0, 4'd0, 4'd0, 3'd0, 4'd13), 1'b1, 4'd13, 32'h0, pc_cur + 32'd4, 0, 0);

		for (int n = 0; n < 40; n++) begin
			f3 = 3'($urandom);
			rd = 4'($urandom);
			rs1 = 4'($urandom);
			rs2 = 4'($urandom);
			alt = 1'($urandom) && (f3 == 3'd0 || f3 == 3'd5);
			if (n % 2 == 0) begin
				issue(enc_r(alt, rs2, rs1, f3, rd), 1'b1, rd,
					alu_ref(f3, alt, regs[rs1], regs[rs2]), pc_cur + 32'd4, 0, 0);
			end else begin
				imm = 12'($urandom);
				if (f3 == 3'd1 || f3 == 3'd5) imm = {1'b0, alt, 5'b0, imm[4:0]};
				if (f3 == 3'd0) alt = 1'b0;
				b = {{20{imm[11]}}, imm};
				issue(enc_i(imm, rs1, f3, rd, opc_op_imm), 1'b1, rd,
					alu_ref(f3, alt, regs[rs1], b), pc_cur + 32'd4, 0, 0);
			end
		end
		v = $urandom;
		issue({v[31:12], 5'd14, 7'b0010111}, 1'b1, 4'd14, pc_cur + {v[31:12], 12'h0},
			pc_cur + 32'd4, 0, 0);

		for (int n = 0; n < 24; n++) begin
			w = int'($urandom % 6);
			f3 = (w < 2) ? 3'(w) : 3'(w + 2);
			rs1 = 4'($urandom);
			rs2 = (n % 4 == 0) ? rs1 : 4'($urandom); // some equal operands
			boff = 13'($urandom);
			boff[0] = 1'b0;
			addr = taken_ref(f3, regs[rs1], regs[rs2]) ? pc_cur + {{19{boff[12]}}, boff} :
				pc_cur + 32'd4;
			issue(enc_b(boff, rs2, rs1, f3), 1'b0, 4'd0, 32'h0, addr, 0, 0);
		end
		for (int n = 0; n < 3; n++) begin
			rd = 4'($urandom);
			joff = 21'($urandom);
			joff[0] = 1'b0;
			issue(enc_j(joff, rd), 1'b1, rd, pc_cur + 32'd4,
				pc_cur + {{11{joff[20]}}, joff}, 0, 0);
			rs1 = 4'($urandom);
			imm = 12'($urandom);
			addr = (regs[rs1] + {{20{imm[11]}}, imm}) & ~32'h1;
			issue(enc_i(imm, rs1, 3'd0, rd, 7'b1100111), 1'b1, rd, pc_cur + 32'd4, addr, 0, 0);
		end

		v = 32'($urandom % 64) * 32'd4;
		issue(enc_i(v[11:0], 4'd0, 3'd0, 4'd10, opc_op_imm), 1'b1, 4'd10, v, pc_cur + 32'd4, 0, 0);
		for (int k = 1; k < 6; k++) begin
			w = int'($urandom % 64);
			addr = 32'(w) * 32'd4;
			b = addr - regs[10];
			issue(enc_s(b[11:0], 4'(k), 4'd10), 1'b0, 4'd0, 32'h0, pc_cur + 32'd4,
				addr, regs[k]);
			shadow_mem[w] = regs[k];
			issue(enc_i(b[11:0], 4'd10, 3'b010, 4'd12, 7'b0000011), 1'b1, 4'd12, shadow_mem[w],
				pc_cur + 32'd4, addr, 0);
		end

		csr_op(3'b010, 4'd7, 4'd0, 12'h300);
		csr_op(3'b001, 4'd3, 4'd5, 12'h305);
		csr_op(3'b010, 4'd4, 4'd6, 12'h305);
		csr_op(3'b001, 4'd8, 4'd9, 12'h342);
		csr_op(3'b010, 4'd2, 4'd0, 12'h342);
		csr_op(3'b010, 4'd8, 4'd9, 12'h340); // unknown address reads zero
		ecall_pc = pc_cur;
		issue(32'h00000073, 1'b0, 4'd0, 32'h0, mtvec_m, 0, 0);
		mepc_m = ecall_pc;
		mcause_m = 32'd11;
		csr_op(3'b010, 4'd9, 4'd0, 12'h341);
		csr_op(3'b010, 4'd9, 4'd0, 12'h342);
		issue(32'h30200073, 1'b0, 4'd0, 32'h0, mepc_m, 0, 0);
		repeat (2) @(negedge clock);
		$display("ALL TESTS PASSED");
		$finish;
	end

endmodule

// ==== exec_core.f ====
+incdir+verilog
verilog/inst_pkg.sv
verilog/csr_pkg.sv
verilog/decoder.sv
verilog/register_file.sv
verilog/alu.sv
verilog/execute_unit.sv
verilog/csr_file.sv
verilog/exec_core.sv
bench/exec_core_tb.sv

// ==== Makefile ====
TOP = exec_core_tb

.PHONY: compile run clean

compile:
	verilator --binary --timing --assert -f exec_core.f --top-module $(TOP) -Mdir obj_dir

run: compile
	out="$$(./obj_dir/V$(TOP))"; echo "$$out"; echo "$$out" | grep -q "ALL TESTS PASSED"

clean:
	rm -rf obj_dir
